// ==== hdl/shift_params.svh ====
`ifndef SHIFT_PARAMS_SVH
`define SHIFT_PARAMS_SVH

// ======================================================================
// datapath and bus geometry
// ======================================================================
`define SHIFT_DATA_W        64
`define SHIFT_ADDR_W        8
`define SHIFT_QUEUE_DEPTH   4

// register map, 64-bit words on 8-byte offsets
`define SHIFT_REG_A         8'h00
`define SHIFT_REG_B         8'h08
`define SHIFT_REG_INSTR     8'h10
`define SHIFT_REG_RESULT    8'h18
`define SHIFT_REG_STATUS    8'h20

// axi response codes
`define SHIFT_RESP_OKAY     2'b00
`define SHIFT_RESP_SLVERR   2'b10

// ======================================================================
// instruction encoding
// ======================================================================
// opcode field, instr[5:0]
`define OP_IVECTOR          6'h01
`define OP_RR               6'h02
`define OP_AMO              6'h2F

// func field, instr[31:26]
`define FN_VSHL             6'h0C
`define FN_VSHR             6'h0D
`define FN_VASR             6'h0E
`define FN_SHIFTR           6'h2F
`define FN_SHIFT31          6'h0F
`define FN_SHIFT63          6'h1F
`define FN_AMOSHL           6'h0C
`define FN_AMOSHR           6'h0D
`define FN_AMOASR           6'h0E
`define FN_AMOROL           6'h0F
// immediate amo forms
`define FN_AMOSHLI          6'h2C
`define FN_AMOSHRI          6'h2D
`define FN_AMOASRI          6'h2E
`define FN_AMOROLI          6'h2F

// shiftop field, instr[25:23]
`define SO_SHL              3'h0
`define SO_SHR              3'h1
`define SO_ASL              3'h2
`define SO_ASR              3'h3
`define SO_ROL              3'h4
`define SO_ROR              3'h5

`endif

// ==== hdl/shiftPkg.sv ====
`include "shift_params.svh"

package shiftPkg;

    // ==================================================================
    // plain vector types
    // ==================================================================
    // operand or result word
    typedef logic [`SHIFT_DATA_W-1:0] shiftWord;

    // opcode [5:0], shiftop [25:23], func [31:26]
    typedef logic [31:0] shiftInstr;

    // shift count, low bits of operand b
    typedef logic [6:0] shiftAmount;

    // axi register offset
    typedef logic [`SHIFT_ADDR_W-1:0] regAddr;

    // ==================================================================
    // structs carried between blocks
    // ==================================================================
    // one queued command, instr in the top bits
    typedef struct packed {
        shiftInstr instr;
        shiftWord  a;
        shiftWord  b;
    } shiftCmd;

    // shifter output and flags, as held in the result slot
    typedef struct packed {
        shiftWord value;
        logic     ov;
        logic     illegal;
    } shiftResult;

    // ==================================================================
    // state machines
    // ==================================================================
    // write side: waiting for a write, or holding bvalid
    typedef enum logic {
        wrIdle,
        wrResp
    } writeState;

    // read side: rdWait parks a RESULT read until the slot fills
    typedef enum logic [1:0] {
        rdIdle,
        rdWait,
        rdResp
    } readState;

endpackage

// ==== hdl/shiftCmdWriter.sv ====
`timescale 1ns/1ns
`include "shift_params.svh"

module shiftCmdWriter (
    input  logic               clk,
    input  logic               arstN,
    input  logic               awvalid,
    output logic               awready,
    input  shiftPkg::regAddr   awaddr,
    input  logic               wvalid,
    output logic               wready,
    input  shiftPkg::shiftWord wdata,
    output logic               bvalid,
    input  logic               bready,
    output logic [1:0]         bresp,
    input  logic               queueFull,
    output logic               pushValid,
    output shiftPkg::shiftCmd  pushCmd
);

    shiftPkg::writeState state;
    shiftPkg::shiftWord  regA;
    shiftPkg::shiftWord  regB;
    logic                isA;
    logic                isB;
    logic                isInstr;
    logic                accept;

    // address decode
    assign isA     = (awaddr == `SHIFT_REG_A);
    assign isB     = (awaddr == `SHIFT_REG_B);
    assign isInstr = (awaddr == `SHIFT_REG_INSTR);

    // address and data are taken together, only when both are offered
    // an INSTR write waits for room in the queue
    assign accept  = (state == shiftPkg::wrIdle) && awvalid && wvalid &&
                     !(isInstr && queueFull);
    assign awready = accept;
    assign wready  = accept;

    // command leaves in the transfer cycle, with the operands as stored so far
    assign pushValid     = accept && isInstr;
    assign pushCmd.instr = wdata[31:0];
    assign pushCmd.a     = regA;
    assign pushCmd.b     = regB;

    assign bvalid = (state == shiftPkg::wrResp);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= shiftPkg::wrIdle;
            regA  <= '0;
            regB  <= '0;
            bresp <= `SHIFT_RESP_OKAY;
        end else begin
            case (state)
                shiftPkg::wrIdle: begin
                    if (accept) begin
                        state <= shiftPkg::wrResp;
                        if (isA) begin
                            regA <= wdata;
                        end
                        if (isB) begin
                            regB <= wdata;
                        end
                        // result, status and holes are not writable
                        bresp <= (isA || isB || isInstr) ? `SHIFT_RESP_OKAY
                                                         : `SHIFT_RESP_SLVERR;
                    end
                end
                shiftPkg::wrResp: begin
                    if (bready) begin
                        state <= shiftPkg::wrIdle;
                    end
                end
                default: state <= shiftPkg::wrIdle;
            endcase
        end
    end

    // response stays up until the host takes it
    bHold: assert property (@(posedge clk) disable iff (!arstN)
        bvalid && !bready |=> bvalid);

endmodule

// ==== hdl/shiftCmdQueue.sv ====
`timescale 1ns/1ns
`include "shift_params.svh"

module shiftCmdQueue (
    input  logic              clk,
    input  logic              arstN,
    input  logic              pushValid,
    input  shiftPkg::shiftCmd pushCmd,
    output logic              full,
    output logic              popValid,
    input  logic              popReady,
    output shiftPkg::shiftCmd popCmd
);

    localparam int Depth = `SHIFT_QUEUE_DEPTH;
    localparam int PtrW  = $clog2(Depth);
    localparam int CntW  = $clog2(Depth + 1);

    shiftPkg::shiftCmd mem [Depth];
    logic [PtrW-1:0]   wrPtr;
    logic [PtrW-1:0]   rdPtr;
    logic [CntW-1:0]   count;
    logic              doPush;
    logic              doPop;

    assign full     = (count == CntW'(Depth));
    assign popValid = (count != '0);
    // head is the registered entry at rdPtr
    assign popCmd   = mem[rdPtr];

    assign doPush = pushValid && !full;
    assign doPop  = popReady && popValid;

    // storage, written at the tail
    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushCmd;
        end
    end

    // pointers wrap at Depth, count tracks occupancy
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            // simultaneous push and pop leave count unchanged
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

    // writer must hold off while full, reader must not pop an empty queue
    noPushFull: assert property (@(posedge clk) disable iff (!arstN)
        pushValid |-> !full);
    noPopEmpty: assert property (@(posedge clk) disable iff (!arstN)
        popReady |-> popValid);

endmodule

// ==== hdl/shiftUnit.sv ====
`timescale 1ns/1ns
`include "shift_params.svh"

module shiftUnit (
    input  shiftPkg::shiftCmd    cmd,
    output shiftPkg::shiftResult res
);

    localparam int W = `SHIFT_DATA_W;

    logic [5:0]           opcode;
    logic [5:0]           func;
    logic [2:0]           shiftop;
    shiftPkg::shiftAmount amt;
    logic [3*W-1:0]       shlWide;
    logic [2*W-1:0]       outMask;
    logic [2*W-1:0]       rolWide;
    logic [2*W-1:0]       rorWide;
    logic                 ovRaw;
    logic [2:0]           sel;
    logic                 legal;
    shiftPkg::shiftWord   opVal;

    // instruction fields
    assign opcode  = cmd.instr[5:0];
    assign func    = cmd.instr[31:26];
    assign shiftop = cmd.instr[25:23];
    assign amt     = cmd.b[6:0];

    // left shift keeps every bit so the lost ones can be inspected
    assign shlWide = {{(2*W){1'b0}}, cmd.a} << amt;
    // one mask bit for each position pushed past bit 63
    assign outMask = ((2*W)'(1) << amt) - (2*W)'(1);
    assign ovRaw   = |((shlWide[3*W-1:W] ^ {(2*W){cmd.a[W-1]}}) & outMask);

    // rotates use the amount modulo W
    assign rolWide = {cmd.a, cmd.a} << amt[$clog2(W)-1:0];
    assign rorWide = {cmd.a, cmd.a} >> amt[$clog2(W)-1:0];

    // ==================================================================
    // decode to a shiftop code
    // ==================================================================
    always_comb begin
        sel   = `SO_SHL;
        legal = 1'b0;
        case (opcode)
            `OP_RR: begin
                // three func forms, op picked by shiftop
                if (func == `FN_SHIFTR || func == `FN_SHIFT31 || func == `FN_SHIFT63) begin
                    sel   = shiftop;
                    legal = (shiftop <= `SO_ROR);
                end
            end
            `OP_AMO: begin
                legal = 1'b1;
                case (func)
                    `FN_AMOSHL, `FN_AMOSHLI: sel = `SO_SHL;
                    `FN_AMOSHR, `FN_AMOSHRI: sel = `SO_SHR;
                    `FN_AMOASR, `FN_AMOASRI: sel = `SO_ASR;
                    `FN_AMOROL, `FN_AMOROLI: sel = `SO_ROL;
                    default:                 legal = 1'b0;
                endcase
            end
            `OP_IVECTOR: begin
                // vector group has no rotates
                legal = 1'b1;
                case (func)
                    `FN_VSHL: sel = `SO_SHL;
                    `FN_VSHR: sel = `SO_SHR;
                    `FN_VASR: sel = `SO_ASR;
                    default:  legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase
    end

    // ==================================================================
    // operation select
    // ==================================================================
    always_comb begin
        case (sel)
            `SO_SHL, `SO_ASL: opVal = shlWide[W-1:0];
            `SO_SHR:          opVal = cmd.a >> amt;
            // counts of W or more give all sign bits
            `SO_ASR:          opVal = shiftPkg::shiftWord'($signed(cmd.a) >>> amt);
            `SO_ROL:          opVal = rolWide[2*W-1:W];
            `SO_ROR:          opVal = rorWide[W-1:0];
            default:          opVal = '0;
        endcase
    end

    // illegal encodings give zero and no overflow
    assign res.value   = legal ? opVal : '0;
    assign res.ov      = legal && ovRaw;
    assign res.illegal = !legal;

endmodule

// ==== hdl/shiftResultReader.sv ====
`timescale 1ns/1ns
`include "shift_params.svh"

module shiftResultReader (
    input  logic               clk,
    input  logic               arstN,
    input  logic               arvalid,
    output logic               arready,
    input  shiftPkg::regAddr   araddr,
    output logic               rvalid,
    input  logic               rready,
    output shiftPkg::shiftWord rdata,
    output logic [1:0]         rresp,
    input  logic               popValid,
    output logic               popReady,
    input  shiftPkg::shiftCmd  popCmd
);

    localparam int W = `SHIFT_DATA_W;

    shiftPkg::readState   state;
    shiftPkg::shiftResult unitRes;
    shiftPkg::shiftResult slot;
    logic                 slotFull;
    logic                 isResult;
    logic                 isStatus;
    logic                 arXfer;
    logic                 takeResult;

    shiftUnit u_shiftUnit (
        .cmd(popCmd),
        .res(unitRes)
    );

    assign isResult = (araddr == `SHIFT_REG_RESULT);
    assign isStatus = (araddr == `SHIFT_REG_STATUS);

    // RESULT stalls on an empty slot, everything else goes at once
    assign arready    = arvalid && (state != shiftPkg::rdResp) && (!isResult || slotFull);
    assign arXfer     = arvalid && arready;
    assign takeResult = arXfer && isResult;

    // refill the slot whenever it is empty
    assign popReady = popValid && !slotFull;
    assign rvalid   = (state == shiftPkg::rdResp);

    // ==================================================================
    // read FSM and slot occupancy
    // ==================================================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= shiftPkg::rdIdle;
            slotFull <= 1'b0;
        end else begin
            if (popReady) begin
                slotFull <= 1'b1;
            end else if (takeResult) begin
                slotFull <= 1'b0;
            end
            case (state)
                shiftPkg::rdIdle: begin
                    if (arXfer) begin
                        state <= shiftPkg::rdResp;
                    end else if (arvalid && isResult) begin
                        state <= shiftPkg::rdWait;
                    end
                end
                shiftPkg::rdWait: begin
                    if (arXfer) begin
                        state <= shiftPkg::rdResp;
                    end else if (!arvalid) begin
                        state <= shiftPkg::rdIdle;
                    end
                end
                shiftPkg::rdResp: begin
                    if (rready) begin
                        state <= shiftPkg::rdIdle;
                    end
                end
                default: state <= shiftPkg::rdIdle;
            endcase
        end
    end

    // slot payload and read data
    always_ff @(posedge clk) begin
        if (popReady) begin
            slot <= unitRes;
        end
        if (arXfer) begin
            if (isResult) begin
                rdata <= slot.value;
                rresp <= `SHIFT_RESP_OKAY;
            end else if (isStatus) begin
                // flags only mean something while a result is held
                rdata <= {{(W-3){1'b0}}, slot.illegal && slotFull, slot.ov && slotFull,
                          slotFull};
                rresp <= `SHIFT_RESP_OKAY;
            end else begin
                rdata <= '0;
                rresp <= `SHIFT_RESP_SLVERR;
            end
        end
    end

    // a held result survives until the host reads it
    slotHold: assert property (@(posedge clk) disable iff (!arstN)
        slotFull && !takeResult |=> slotFull && $stable(slot));

endmodule

// ==== hdl/shiftAxiTop.sv ====
`timescale 1ns/1ns

module shiftAxiTop (
    input  logic               clk,
    input  logic               arstN,
    // write address
    input  logic               awvalid,
    output logic               awready,
    input  shiftPkg::regAddr   awaddr,
    // write data
    input  logic               wvalid,
    output logic               wready,
    input  shiftPkg::shiftWord wdata,
    // write response
    output logic               bvalid,
    input  logic               bready,
    output logic [1:0]         bresp,
    // read address
    input  logic               arvalid,
    output logic               arready,
    input  shiftPkg::regAddr   araddr,
    // read data
    output logic               rvalid,
    input  logic               rready,
    output shiftPkg::shiftWord rdata,
    output logic [1:0]         rresp
);

    // writer to queue
    logic              pushValid;
    shiftPkg::shiftCmd pushCmd;
    logic              queueFull;
    // queue to reader
    logic              popValid;
    logic              popReady;
    shiftPkg::shiftCmd popCmd;

    shiftCmdWriter u_shiftCmdWriter (
        .clk      (clk),
        .arstN    (arstN),
        .awvalid  (awvalid),
        .awready  (awready),
        .awaddr   (awaddr),
        .wvalid   (wvalid),
        .wready   (wready),
        .wdata    (wdata),
        .bvalid   (bvalid),
        .bready   (bready),
        .bresp    (bresp),
        .queueFull(queueFull),
        .pushValid(pushValid),
        .pushCmd  (pushCmd)
    );

    shiftCmdQueue u_shiftCmdQueue (
        .clk      (clk),
        .arstN    (arstN),
        .pushValid(pushValid),
        .pushCmd  (pushCmd),
        .full     (queueFull),
        .popValid (popValid),
        .popReady (popReady),
        .popCmd   (popCmd)
    );

    shiftResultReader u_shiftResultReader (
        .clk     (clk),
        .arstN   (arstN),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .popValid(popValid),
        .popReady(popReady),
        .popCmd  (popCmd)
    );

endmodule

// ==== verif/shiftTb.sv ====
`timescale 1ns/1ns
`include "shift_params.svh"

module shiftTb;

    localparam int TimeoutCycles = 100;
    localparam logic [5:0] RrFuncs [3] = '{`FN_SHIFTR, `FN_SHIFT31, `FN_SHIFT63};
    localparam logic [5:0] AmoFuncs [8] = '{`FN_AMOSHL, `FN_AMOSHR, `FN_AMOASR, `FN_AMOROL,
                                            `FN_AMOSHLI, `FN_AMOSHRI, `FN_AMOASRI, `FN_AMOROLI};
    localparam logic [5:0] VecFuncs [3] = '{`FN_VSHL, `FN_VSHR, `FN_VASR};
    // corner amounts, the fifth pass of each loop takes a random one
    localparam logic [6:0] EdgeAmounts [4] = '{7'd0, 7'd63, 7'd64, 7'd127};

    logic clk;
    logic arstN;
    logic awvalid;
    logic awready;
    shiftPkg::regAddr awaddr;
    logic wvalid;
    logic wready;
    shiftPkg::shiftWord wdata;
    logic bvalid;
    logic bready;
    logic [1:0] bresp;
    logic arvalid;
    logic arready;
    shiftPkg::regAddr araddr;
    logic rvalid;
    logic rready;
    shiftPkg::shiftWord rdata;
    logic [1:0] rresp;

    // expectations seen by the checkers
    shiftPkg::shiftWord expData;
    logic [1:0] expRresp;
    logic [1:0] expBresp;
    logic expectStall;
    shiftPkg::shiftResult expQ [$];
    // operand registers as the host last wrote them
    shiftPkg::shiftWord mdlA;
    shiftPkg::shiftWord mdlB;
    logic [31:0] lfsr;

    shiftAxiTop u_shiftAxiTop (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "run stopped");
    endtask

    // ======================================================================
    // checkers
    // ======================================================================
    rdataChk: assert property (@(posedge clk) disable iff (!arstN)
        rvalid && rready |-> rdata == expData)
        else abortRun($sformatf("Fail rdata got %h expected %h", rdata, expData));
    rrespChk: assert property (@(posedge clk) disable iff (!arstN)
        rvalid && rready |-> rresp == expRresp)
        else abortRun($sformatf("Fail rresp got %h expected %h", rresp, expRresp));
    brespChk: assert property (@(posedge clk) disable iff (!arstN)
        bvalid && bready |-> bresp == expBresp)
        else abortRun($sformatf("Fail bresp got %h expected %h", bresp, expBresp));
    // full queue must hold the write channels off
    stallChk: assert property (@(posedge clk) disable iff (!arstN)
        expectStall |-> !awready)
        else abortRun($sformatf("Fail awready got %h expected %h", awready, 1'b0));
    wstallChk: assert property (@(posedge clk) disable iff (!arstN)
        expectStall |-> !wready)
        else abortRun($sformatf("Fail wready got %h expected %h", wready, 1'b0));

    // ======================================================================
    // stimulus helpers
    // ======================================================================
    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic nextBit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic shiftPkg::shiftWord randBits(input int n);
        shiftPkg::shiftWord v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], nextBit()};
        end
        return v;
    endfunction

    function automatic logic [31:0] makeInstr(input logic [5:0] fn, input logic [2:0] so,
                                              input logic [5:0] op);
        return {fn, so, 17'b0, op};
    endfunction

    // reference shifter, bit by bit from the encoding rules
    function automatic shiftPkg::shiftResult modelShift(input logic [31:0] instr,
                                                        input shiftPkg::shiftWord a,
                                                        input shiftPkg::shiftWord b);
        shiftPkg::shiftResult r;
        logic [5:0] fn;
        logic [2:0] opSel;
        logic ok;
        logic sign;
        logic lost;
        int k;
        int src;
        fn = instr[31:26];
        k = int'(b[6:0]);
        sign = a[63];
        ok = 1'b1;
        opSel = instr[25:23];
        case (instr[5:0])
            `OP_RR: ok = (fn == `FN_SHIFTR || fn == `FN_SHIFT31 || fn == `FN_SHIFT63) &&
                         (opSel <= `SO_ROR);
            `OP_AMO, `OP_IVECTOR: begin
                // low two func bits pick the op in both groups
                case (fn[3:0])
                    4'hC: opSel = `SO_SHL;
                    4'hD: opSel = `SO_SHR;
                    4'hE: opSel = `SO_ASR;
                    default: opSel = `SO_ROL;
                endcase
                if (instr[5:0] == `OP_AMO) begin
                    ok = (fn[5:4] == 2'b00 || fn[5:4] == 2'b10) && fn[3:2] == 2'b11;
                end else begin
                    ok = fn == `FN_VSHL || fn == `FN_VSHR || fn == `FN_VASR;
                end
            end
            default: ok = 1'b0;
        endcase
        for (int i = 0; i < 64; i++) begin
            case (opSel)
                `SO_SHL, `SO_ASL: r.value[6'(i)] = (i >= k) ? a[6'(i - k)] : 1'b0;
                `SO_SHR: r.value[6'(i)] = (i + k < 64) ? a[6'(i + k)] : 1'b0;
                `SO_ASR: r.value[6'(i)] = (i + k < 64) ? a[6'(i + k)] : sign;
                `SO_ROL: r.value[6'(i)] = a[6'(i - k)];
                default: r.value[6'(i)] = a[6'(i + k)];
            endcase
        end
        // pushed-out bits of the zero-extended a must all match the sign
        r.ov = 1'b0;
        for (int p = 0; p < k; p++) begin
            src = p + 64 - k;
            lost = (src >= 0) ? a[6'(src)] : 1'b0;
            if (lost != sign) begin
                r.ov = 1'b1;
            end
        end
        r.illegal = !ok;
        if (!ok) begin
            r.value = '0;
            r.ov = 1'b0;
        end
        return r;
    endfunction

    task automatic writeReg(input shiftPkg::regAddr addr, input shiftPkg::shiftWord data,
                            input logic [1:0] resp);
        int cnt;
        cnt = 0;
        @(posedge clk);
        awvalid <= 1'b1;
        awaddr <= addr;
        wvalid <= 1'b1;
        wdata <= data;
        expBresp <= resp;
        @(negedge clk);
        while (!awready) begin
            cnt = cnt + 1;
            if (cnt > TimeoutCycles) abortRun("timeout waiting for the write to be accepted");
            @(negedge clk);
        end
        // address and data channels are accepted in the same cycle
        if (!wready) begin
            abortRun($sformatf("Fail wready got %h expected %h", wready, 1'b1));
        end
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        cnt = 0;
        @(negedge clk);
        while (!bvalid) begin
            cnt = cnt + 1;
            if (cnt > TimeoutCycles) abortRun("timeout waiting for the write response");
            @(negedge clk);
        end
        // bready is always high, so this edge takes the response
        @(posedge clk);
    endtask

    task automatic readReg(input shiftPkg::regAddr addr, input shiftPkg::shiftWord data,
                           input logic [1:0] resp);
        int cnt;
        cnt = 0;
        @(posedge clk);
        arvalid <= 1'b1;
        araddr <= addr;
        expData <= data;
        expRresp <= resp;
        @(negedge clk);
        while (!arready) begin
            cnt = cnt + 1;
            if (cnt > TimeoutCycles) abortRun("timeout waiting for the read to be accepted");
            @(negedge clk);
        end
        @(posedge clk);
        arvalid <= 1'b0;
        cnt = 0;
        @(negedge clk);
        while (!rvalid) begin
            cnt = cnt + 1;
            if (cnt > TimeoutCycles) abortRun("timeout waiting for read data");
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic writeOperands(input shiftPkg::shiftWord a, input shiftPkg::shiftWord b);
        mdlA = a;
        mdlB = b;
        writeReg(`SHIFT_REG_A, a, `SHIFT_RESP_OKAY);
        writeReg(`SHIFT_REG_B, b, `SHIFT_RESP_OKAY);
    endtask

    task automatic issueInstr(input logic [31:0] instr);
        expQ.push_back(modelShift(instr, mdlA, mdlB));
        writeReg(`SHIFT_REG_INSTR, {32'b0, instr}, `SHIFT_RESP_OKAY);
    endtask

    task automatic readResult();
        shiftPkg::shiftResult r;
        if (expQ.size() == 0) abortRun("a result was read with nothing expected");
        r = expQ.pop_front();
        readReg(`SHIFT_REG_RESULT, r.value, `SHIFT_RESP_OKAY);
    endtask

    // one command end to end, STATUS checked while the result is held
    task automatic runCmd(input logic [31:0] instr, input shiftPkg::shiftWord a,
                          input logic [6:0] amt);
        shiftPkg::shiftResult r;
        shiftPkg::shiftWord upper;
        upper = randBits(57);
        writeOperands(a, {upper[56:0], amt});
        issueInstr(instr);
        r = expQ[$];
        readReg(`SHIFT_REG_STATUS, {61'b0, r.illegal, r.ov, 1'b1}, `SHIFT_RESP_OKAY);
        readResult();
    endtask

    function automatic logic [6:0] pickAmount(input int n);
        return (n < 4) ? EdgeAmounts[2'(n)] : 7'(randBits(7));
    endfunction

    // ======================================================================
    // test groups
    // ======================================================================
    task automatic testRr();
        for (int f = 0; f < 3; f++) begin
            for (int s = 0; s < 6; s++) begin
                for (int n = 0; n < 5; n++) begin
                    runCmd(makeInstr(RrFuncs[2'(f)], 3'(s), `OP_RR), randBits(64),
                           pickAmount(n));
                end
            end
        end
    endtask

    task automatic testAmoVector();
        for (int f = 0; f < 8; f++) begin
            runCmd(makeInstr(AmoFuncs[3'(f)], 3'd0, `OP_AMO), randBits(64), pickAmount(f % 5));
        end
        for (int f = 0; f < 3; f++) begin
            runCmd(makeInstr(VecFuncs[2'(f)], 3'd0, `OP_IVECTOR), randBits(64), pickAmount(f));
        end
        // unlisted encodings
        runCmd(makeInstr(`FN_SHIFTR, 3'd6, `OP_RR), randBits(64), 7'd5);
        runCmd(makeInstr(`FN_SHIFT63, 3'd7, `OP_RR), randBits(64), 7'd5);
        runCmd(makeInstr(6'h00, `SO_SHL, `OP_RR), randBits(64), 7'd5);
        runCmd(makeInstr(6'h10, 3'd0, `OP_AMO), randBits(64), 7'd5);
        runCmd(makeInstr(`FN_SHIFT31, 3'd0, `OP_IVECTOR), randBits(64), 7'd5);
        runCmd(makeInstr(`FN_SHIFTR, `SO_SHL, 6'h03), randBits(64), 7'd5);
    endtask

    task automatic testOverflow();
        // positive and negative, with and without lost bits
        runCmd(makeInstr(`FN_SHIFTR, `SO_SHL, `OP_RR), 64'h0000_0000_0000_0001, 7'd4);
        runCmd(makeInstr(`FN_SHIFTR, `SO_ASL, `OP_RR), 64'h00F0_0000_0000_0000, 7'd12);
        runCmd(makeInstr(`FN_SHIFTR, `SO_SHL, `OP_RR), 64'hFFFF_FFFF_FFFF_FFF0, 7'd8);
        runCmd(makeInstr(`FN_SHIFTR, `SO_ASL, `OP_RR), 64'h8000_0000_0000_0000, 7'd4);
        runCmd(makeInstr(`FN_SHIFT31, `SO_ROR, `OP_RR), 64'hFFFF_FFFF_FFFF_FFFF, 7'd64);
        runCmd(makeInstr(`FN_SHIFT63, `SO_SHR, `OP_RR), 64'h7FFF_0000_0000_0000, 7'd100);
    endtask

    task automatic testBackPressure();
        writeOperands(randBits(64), randBits(64));
        // one in the slot, four in the queue
        for (int i = 0; i < 5; i++) begin
            issueInstr(makeInstr(`FN_SHIFTR, 3'(i), `OP_RR));
        end
        fork
            issueInstr(makeInstr(`FN_SHIFT63, `SO_ROR, `OP_RR));
            begin
                @(posedge clk);
                expectStall <= 1'b1;
                repeat (6) @(posedge clk);
                expectStall <= 1'b0;
                readResult();
            end
        join
        repeat (5) readResult();
    endtask

    task automatic testErrors();
        writeOperands(randBits(64), randBits(64));
        issueInstr(makeInstr(`FN_SHIFTR, `SO_ASR, `OP_RR));
        writeReg(`SHIFT_REG_RESULT, randBits(64), `SHIFT_RESP_SLVERR);
        writeReg(`SHIFT_REG_STATUS, randBits(64), `SHIFT_RESP_SLVERR);
        writeReg(8'h28, randBits(64), `SHIFT_RESP_SLVERR);
        readResult();
        // operands must be the ones from before the rejected writes
        issueInstr(makeInstr(`FN_AMOROLI, 3'd0, `OP_AMO));
        readResult();
        readReg(8'h30, '0, `SHIFT_RESP_SLVERR);
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        lfsr = 32'h1b7e_e251;
        arstN = 1'b0;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        bready = 1'b0;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b0;
        expData = '0;
        expRresp = '0;
        expBresp = '0;
        expectStall = 1'b0;
        mdlA = '0;
        mdlB = '0;
        repeat (8) @(posedge clk);
        arstN <= 1'b1;
        bready <= 1'b1;
        rready <= 1'b1;
        @(negedge clk);
        resetChk: assert (!bvalid && !rvalid && !awready && !wready && !arready)
            else abortRun("handshake outputs were not idle after reset");
        readReg(`SHIFT_REG_STATUS, '0, `SHIFT_RESP_OKAY);
        testRr();
        testAmoVector();
        testOverflow();
        testBackPressure();
        testErrors();
        if (expQ.size() != 0) begin
            abortRun("expected results were left unread");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// ==== compile.f ====
+incdir+hdl
hdl/shiftPkg.sv
hdl/shiftCmdWriter.sv
hdl/shiftCmdQueue.sv
hdl/shiftUnit.sv
hdl/shiftResultReader.sv
hdl/shiftAxiTop.sv
verif/shiftTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the shift unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module shiftTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/VshiftTb > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "Testbench failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "simulator exited with status $simStatus"
    exit 1
fi
exit 0
